/* axi4s_probe_pkg.sv */
// stream probe shared definitions
package axi4s_probe_pkg;

   // counter widths
   localparam int pkt_cnt_wid    = 50;
   localparam int byte_cnt_wid   = 56;
   localparam int pkt_byte_wid   = 16;  // bytes within one packet
   localparam int beat_bytes_wid = 8;   // popcount of tkeep on one beat

   // what the counters count
   typedef enum logic [1:0] {
      mode_good   = 2'd0,  // accepted beats, error-free packets
      mode_ovfl   = 2'd1,  // beats offered while tready low
      mode_errors = 2'd2,  // accepted beats, errored packets
      mode_idle   = 2'd3   // counts nothing
   } probe_mode_t;

   // control register, occupies wdata[3:0]
   typedef struct packed {
      logic        clear;
      logic        latch;  // snapshots load on control write only
      probe_mode_t mode;
   } probe_ctrl_t;

   // one qualified beat
   typedef struct packed {
      logic                      incr;
      logic                      last;
      logic                      err;
      logic [beat_bytes_wid-1:0] bytes;
   } beat_t;

   typedef struct packed {
      logic [pkt_cnt_wid-1:0]  pkt_cnt;
      logic [byte_cnt_wid-1:0] byte_cnt;
   } count_t;

   // monitored stream control lines
   typedef struct packed {
      logic tvalid;
      logic tready;
      logic tlast;
   } line_flags_t;

   // single-cycle register request, wr and rd never both high
   typedef struct packed {
      logic        wr;
      logic        rd;
      logic [7:0]  addr;
      logic [31:0] wdata;
   } reg_req_t;

   // register map
   localparam logic [7:0] reg_ctrl_addr     = 8'h00;
   localparam logic [7:0] reg_pkt_hi_addr   = 8'h04;
   localparam logic [7:0] reg_pkt_lo_addr   = 8'h08;
   localparam logic [7:0] reg_byte_hi_addr  = 8'h0C;
   localparam logic [7:0] reg_byte_lo_addr  = 8'h10;
   localparam logic [7:0] reg_monitor_addr  = 8'h14;
   localparam logic [7:0] reg_activity_addr = 8'h18;

endpackage

/* probe_beat_qualifier.sv */
// stream beat qualifier
`timescale 1ns/1ps

module probe_beat_qualifier #(
   parameter int data_byte_wid = 4
) (
   input  logic                               axi4s_if,
   input  logic                               srst,
   input  logic                               tvalid,
   input  logic                               tready,
   input  logic                               tlast,
   input  logic                               tuser,
   input  logic [data_byte_wid-1:0]           tkeep,
   input  axi4s_probe_pkg::probe_ctrl_t       ctrl,
   output axi4s_probe_pkg::beat_t             beat,
   output axi4s_probe_pkg::line_flags_t       lines
);

   logic                                      incr_nxt;
   logic [axi4s_probe_pkg::beat_bytes_wid-1:0] bytes_nxt;

   // number of valid bytes on the beat
   function automatic logic [axi4s_probe_pkg::beat_bytes_wid-1:0] count_ones(
      input logic [data_byte_wid-1:0] keep
   );
      logic [axi4s_probe_pkg::beat_bytes_wid-1:0] cnt;
      cnt = '0;
      for (int i = 0; i < data_byte_wid; i++) begin
         cnt = cnt + {{(axi4s_probe_pkg::beat_bytes_wid-1){1'b0}}, keep[i]};
      end
      return cnt;
   endfunction

   // mode rule
   always_comb begin
      case (ctrl.mode)
         axi4s_probe_pkg::mode_good:   incr_nxt = tvalid && tready;
         axi4s_probe_pkg::mode_errors: incr_nxt = tvalid && tready;  // err sorted out downstream
         axi4s_probe_pkg::mode_ovfl:   incr_nxt = tvalid && !tready;
         default:                      incr_nxt = 1'b0;
      endcase
   end

   assign bytes_nxt = count_ones(tkeep);

   always_ff @(posedge axi4s_if) begin
      if (srst) begin
         beat.incr <= 1'b0;
      end else begin
         beat.incr <= incr_nxt;
      end
   end

   // beat payload, only meaningful with incr
   always_ff @(posedge axi4s_if) begin
      beat.last  <= tlast;
      beat.err   <= tuser;
      beat.bytes <= bytes_nxt;
   end

   // registered lines for monitor and activity
   always_ff @(posedge axi4s_if) begin
      if (srst) begin
         lines <= '0;
      end else begin
         lines.tvalid <= tvalid;
         lines.tready <= tready;
         lines.tlast  <= tlast;
      end
   end

endmodule

/* probe_counters.sv */
// packet and byte counter engine
`timescale 1ns/1ps

module probe_counters (
   input  logic                         axi4s_if,
   input  logic                         srst,
   input  axi4s_probe_pkg::beat_t       beat,
   input  axi4s_probe_pkg::probe_mode_t mode,
   input  logic                         clear_evt,
   output axi4s_probe_pkg::count_t      counts
);

   localparam int pkt_cnt_wid  = axi4s_probe_pkg::pkt_cnt_wid;
   localparam int byte_cnt_wid = axi4s_probe_pkg::byte_cnt_wid;
   localparam int pkt_byte_wid = axi4s_probe_pkg::pkt_byte_wid;
   localparam int bytes_wid    = axi4s_probe_pkg::beat_bytes_wid;

   logic [pkt_byte_wid-1:0] acc;        // bytes of the packet so far
   logic [pkt_byte_wid-1:0] acc_sum;
   logic                    pkt_end;
   logic                    keep;
   logic                    pkt_add;    // stage 1, finished packet to be counted
   logic [pkt_byte_wid-1:0] pkt_bytes;  // stage 1, its byte total
   logic [pkt_cnt_wid-1:0]  pkt_base;
   logic [byte_cnt_wid-1:0] byte_base;

   assign acc_sum = acc + {{(pkt_byte_wid-bytes_wid){1'b0}}, beat.bytes};
   assign pkt_end = beat.incr && beat.last;

   // is the finished packet kept
   always_comb begin
      case (mode)
         axi4s_probe_pkg::mode_good:   keep = !beat.err;
         axi4s_probe_pkg::mode_errors: keep = beat.err;
         axi4s_probe_pkg::mode_ovfl:   keep = 1'b1;
         default:                      keep = 1'b0;
      endcase
   end

   // per-packet accumulator
   always_ff @(posedge axi4s_if) begin
      if (srst) begin
         acc <= '0;
      end else if (pkt_end) begin
         acc <= '0;  // restarts even when the packet is dropped
      end else if (beat.incr) begin
         acc <= acc_sum;
      end
   end

   always_ff @(posedge axi4s_if) begin
      if (srst) begin
         pkt_add <= 1'b0;
      end else begin
         pkt_add <= pkt_end && keep;
      end
   end

   always_ff @(posedge axi4s_if) begin
      if (pkt_end) begin
         pkt_bytes <= acc_sum;
      end
   end

   // clear wins as the base, a same-cycle increment lands on zero
   always_comb begin
      if (clear_evt) begin
         pkt_base  = '0;
         byte_base = '0;
      end else begin
         pkt_base  = counts.pkt_cnt;
         byte_base = counts.byte_cnt;
      end
   end

   always_ff @(posedge axi4s_if) begin
      if (srst) begin
         counts <= '0;
      end else if (pkt_add) begin
         counts.pkt_cnt  <= pkt_base + {{(pkt_cnt_wid-1){1'b0}}, 1'b1};
         counts.byte_cnt <= byte_base
                            + {{(byte_cnt_wid-pkt_byte_wid){1'b0}}, pkt_bytes};
      end else begin
         counts.pkt_cnt  <= pkt_base;
         counts.byte_cnt <= byte_base;
      end
   end

endmodule

/* probe_reg_file.sv */
// probe register file
`timescale 1ns/1ps

module probe_reg_file (
   input  logic                         axi4s_if,
   input  logic                         srst,
   input  axi4s_probe_pkg::reg_req_t    reg_req,
   input  axi4s_probe_pkg::count_t      counts,
   input  axi4s_probe_pkg::line_flags_t lines,
   output logic [31:0]                  reg_rd_data,
   output logic                         reg_rd_valid,
   output axi4s_probe_pkg::probe_ctrl_t ctrl,
   output logic                         clear_evt
);

   localparam int pkt_cnt_wid  = axi4s_probe_pkg::pkt_cnt_wid;
   localparam int byte_cnt_wid = axi4s_probe_pkg::byte_cnt_wid;
   localparam int pkt_hi_wid   = pkt_cnt_wid - 32;
   localparam int byte_hi_wid  = byte_cnt_wid - 32;

   axi4s_probe_pkg::probe_ctrl_t ctrl_wdata;
   axi4s_probe_pkg::count_t      snap;      // counts as seen by software
   axi4s_probe_pkg::line_flags_t activity;  // sticky since last read
   logic                         ctrl_wr;
   logic                         ctrl_wr_evt;
   logic                         act_rd;
   logic [31:0]                  rd_mux;

   // request decode
   assign ctrl_wr    = reg_req.wr && (reg_req.addr == axi4s_probe_pkg::reg_ctrl_addr);
   assign act_rd     = reg_req.rd && (reg_req.addr == axi4s_probe_pkg::reg_activity_addr);
   assign ctrl_wdata = axi4s_probe_pkg::probe_ctrl_t'(reg_req.wdata[3:0]);

   // control register, clear is a pulse and never stored
   always_ff @(posedge axi4s_if) begin
      if (srst) begin
         ctrl <= '0;
      end else if (ctrl_wr) begin
         ctrl <= '{clear: 1'b0, latch: ctrl_wdata.latch, mode: ctrl_wdata.mode};
      end
   end

   always_ff @(posedge axi4s_if) begin
      if (srst) begin
         clear_evt   <= 1'b0;
         ctrl_wr_evt <= 1'b0;
      end else begin
         clear_evt   <= ctrl_wr && ctrl_wdata.clear;
         ctrl_wr_evt <= ctrl_wr;
      end
   end

   // count snapshots
   always_ff @(posedge axi4s_if) begin
      if (srst) begin
         snap <= '0;
      end else if (!ctrl.latch || ctrl_wr_evt) begin
         snap <= counts;  // free-running unless latched
      end
   end

   // activity flags, cleared by their own read
   always_ff @(posedge axi4s_if) begin
      if (srst) begin
         activity <= '0;
      end else if (act_rd) begin
         activity <= '0;
      end else begin
         activity <= activity | lines;
      end
   end

   // read mux
   always_comb begin
      case (reg_req.addr)
         axi4s_probe_pkg::reg_ctrl_addr: begin
            rd_mux = {28'd0, ctrl};
         end
         axi4s_probe_pkg::reg_pkt_hi_addr: begin
            rd_mux = {{(32-pkt_hi_wid){1'b0}}, snap.pkt_cnt[pkt_cnt_wid-1:32]};
         end
         axi4s_probe_pkg::reg_pkt_lo_addr: begin
            rd_mux = snap.pkt_cnt[31:0];
         end
         axi4s_probe_pkg::reg_byte_hi_addr: begin
            rd_mux = {{(32-byte_hi_wid){1'b0}}, snap.byte_cnt[byte_cnt_wid-1:32]};
         end
         axi4s_probe_pkg::reg_byte_lo_addr: begin
            rd_mux = snap.byte_cnt[31:0];
         end
         axi4s_probe_pkg::reg_monitor_addr: begin
            rd_mux = {29'd0, lines};  // live view
         end
         axi4s_probe_pkg::reg_activity_addr: begin
            rd_mux = {29'd0, activity};
         end
         default: begin
            rd_mux = '0;
         end
      endcase
   end

   always_ff @(posedge axi4s_if) begin
      if (srst) begin
         reg_rd_valid <= 1'b0;
      end else begin
         reg_rd_valid <= reg_req.rd;
      end
   end

   // read data holds until the next read
   always_ff @(posedge axi4s_if) begin
      if (reg_req.rd) begin
         reg_rd_data <= rd_mux;
      end
   end

endmodule

/* axi4s_probe_top.sv */
// stream probe top level
`timescale 1ns/1ps

module axi4s_probe_top #(
   parameter int data_byte_wid = 4
) (
   input  logic                      axi4s_if,
   input  logic                      srst,
   // observed stream, nothing driven back
   input  logic                      tvalid,
   input  logic                      tready,
   input  logic                      tlast,
   input  logic                      tuser,
   input  logic [data_byte_wid-1:0]  tkeep,
   // register port
   input  axi4s_probe_pkg::reg_req_t reg_req,
   output logic [31:0]               reg_rd_data,
   output logic                      reg_rd_valid
);

   axi4s_probe_pkg::probe_ctrl_t ctrl;
   axi4s_probe_pkg::beat_t       beat;
   axi4s_probe_pkg::count_t      counts;
   axi4s_probe_pkg::line_flags_t lines;
   logic                         clear_evt;

   probe_beat_qualifier #(
      .data_byte_wid (data_byte_wid)
   ) probe_beat_qualifier_i (
      .axi4s_if (axi4s_if),
      .srst     (srst),
      .tvalid   (tvalid),
      .tready   (tready),
      .tlast    (tlast),
      .tuser    (tuser),
      .tkeep    (tkeep),
      .ctrl     (ctrl),
      .beat     (beat),
      .lines    (lines)
   );

   probe_counters probe_counters_i (
      .axi4s_if  (axi4s_if),
      .srst      (srst),
      .beat      (beat),
      .mode      (ctrl.mode),
      .clear_evt (clear_evt),
      .counts    (counts)
   );

   probe_reg_file probe_reg_file_i (
      .axi4s_if     (axi4s_if),
      .srst         (srst),
      .reg_req      (reg_req),
      .counts       (counts),
      .lines        (lines),
      .reg_rd_data  (reg_rd_data),
      .reg_rd_valid (reg_rd_valid),
      .ctrl         (ctrl),
      .clear_evt    (clear_evt)
   );

endmodule

/* tb_axi4s_probe.sv */
// stream probe testbench
`timescale 1ns/1ps

module tb_axi4s_probe;

   localparam int data_byte_wid = 4;
   localparam int max_cycles    = 20000;  // well beyond the full sequence
   localparam logic [31:0] rng_seed = 32'd20245;

   logic                      axi4s_if;
   logic                      srst;
   logic                      tvalid;
   logic                      tready;
   logic                      tlast;
   logic                      tuser;
   logic [data_byte_wid-1:0]  tkeep;
   axi4s_probe_pkg::reg_req_t reg_req;
   logic [31:0]               reg_rd_data;
   logic                      reg_rd_valid;

   // reference model state
   axi4s_probe_pkg::probe_mode_t                model_mode;
   logic                                        model_latch;
   logic [axi4s_probe_pkg::pkt_cnt_wid-1:0]     exp_pkt;
   logic [axi4s_probe_pkg::byte_cnt_wid-1:0]    exp_bytes;
   logic [axi4s_probe_pkg::pkt_cnt_wid-1:0]     snap_pkt;   // value held while latched
   logic [axi4s_probe_pkg::byte_cnt_wid-1:0]    snap_bytes;
   logic [15:0]                                 acc;        // bytes of the open packet
   logic [2:0]                                  act_exp;    // tvalid, tready, tlast seen
   logic [31:0]                                 rng;
   int unsigned                                 cycle_cnt = 0;

   axi4s_probe_top #(
      .data_byte_wid (data_byte_wid)
   ) axi4s_probe_top_i (
      .axi4s_if     (axi4s_if),
      .srst         (srst),
      .tvalid       (tvalid),
      .tready       (tready),
      .tlast        (tlast),
      .tuser        (tuser),
      .tkeep        (tkeep),
      .reg_req      (reg_req),
      .reg_rd_data  (reg_rd_data),
      .reg_rd_valid (reg_rd_valid)
   );

   initial begin
      axi4s_if = 1'b0;
      forever #20 axi4s_if = ~axi4s_if;
   end

   task automatic end_in_failure();
      $display("Simulation finished: FAIL");
      $fatal(1, "testbench stopped at the first error");
   endtask

   always @(posedge axi4s_if) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == max_cycles) begin
         $display("timeout after %0d cycles, the sequence did not complete", max_cycles);
         end_in_failure();
      end
   end

   // xorshift32
   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // one stream cycle, model applies the qualification rule to it
   task automatic drive_cycle(input logic v, input logic r, input logic l, input logic u,
                              input int nbytes);
      logic counted;
      logic kept;
      tvalid = v;
      tready = r;
      tlast  = l;
      tuser  = u;
      for (int i = 0; i < data_byte_wid; i++) begin
         tkeep[i] = v && (i < nbytes);  // contiguous from byte 0
      end
      case (model_mode)
         axi4s_probe_pkg::mode_good:   counted = v && r;
         axi4s_probe_pkg::mode_errors: counted = v && r;
         axi4s_probe_pkg::mode_ovfl:   counted = v && !r;
         default:                      counted = 1'b0;
      endcase
      if (counted) begin
         acc = acc + 16'(nbytes);
         if (l) begin
            kept = (model_mode == axi4s_probe_pkg::mode_good)   ? !u :
                   (model_mode == axi4s_probe_pkg::mode_errors) ? u : 1'b1;
            if (kept) begin
               exp_pkt   = exp_pkt + 1'b1;
               exp_bytes = exp_bytes + {40'd0, acc};
            end
            acc = '0;
         end
      end
      act_exp = act_exp | {v, r, l};
      @(posedge axi4s_if);
      #2;
      assert (reg_rd_valid === 1'b0) else begin
         $display("reg_rd_valid came high with no read one cycle before");
         end_in_failure();
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 0);
   endtask

   // single read, data due with reg_rd_valid one cycle later
   task automatic read_check(input logic [7:0] addr, input string name,
                             input logic [31:0] want);
      reg_req      = '0;
      reg_req.rd   = 1'b1;
      reg_req.addr = addr;
      @(posedge axi4s_if);
      #2;
      reg_req = '0;
      assert (reg_rd_valid === 1'b1) else begin
         $display("no reg_rd_valid one cycle after the read of %s", name);
         end_in_failure();
      end
      assert (reg_rd_data === want) else begin
         $display("CHECK FAILED reg_rd_data (%s): got 0x%08h, expected 0x%08h",
                  name, reg_rd_data, want);
         end_in_failure();
      end
      if (addr == axi4s_probe_pkg::reg_activity_addr) begin
         act_exp = '0;  // clear on read
      end
   endtask

   task automatic write_ctrl(input logic clear, input logic latch,
                             input axi4s_probe_pkg::probe_mode_t mode);
      reg_req       = '0;
      reg_req.wr    = 1'b1;
      reg_req.addr  = axi4s_probe_pkg::reg_ctrl_addr;
      reg_req.wdata = {28'd0, clear, latch, mode};
      @(posedge axi4s_if);
      #2;
      reg_req     = '0;
      model_mode  = mode;
      model_latch = latch;
      // snapshot takes the counts before a clear reaches them
      snap_pkt    = exp_pkt;
      snap_bytes  = exp_bytes;
      if (clear) begin
         exp_pkt   = '0;
         exp_bytes = '0;
      end
      idle_cycles(3);
   endtask

   task automatic check_counts();
      logic [axi4s_probe_pkg::pkt_cnt_wid-1:0]  want_pkt;
      logic [axi4s_probe_pkg::byte_cnt_wid-1:0] want_bytes;
      want_pkt   = model_latch ? snap_pkt : exp_pkt;
      want_bytes = model_latch ? snap_bytes : exp_bytes;
      read_check(axi4s_probe_pkg::reg_pkt_hi_addr, "pkt_hi", 32'(want_pkt >> 32));
      read_check(axi4s_probe_pkg::reg_pkt_lo_addr, "pkt_lo", want_pkt[31:0]);
      read_check(axi4s_probe_pkg::reg_byte_hi_addr, "byte_hi", 32'(want_bytes >> 32));
      read_check(axi4s_probe_pkg::reg_byte_lo_addr, "byte_lo", want_bytes[31:0]);
   endtask

   // random packet with gaps and tready stalls, stalled beats hold their lines
   task automatic send_packet();
      int          len;
      int          nbytes;
      logic        last;
      logic        user;
      logic [31:0] rnd;
      len = 1 + int'(next_rand() % 32'd6);
      for (int b = 0; b < len; b++) begin
         last   = (b == len - 1);
         user   = (next_rand() % 32'd3) == 32'd0;
         nbytes = last ? 1 + int'(next_rand() % 32'd4) : data_byte_wid;
         rnd    = next_rand();
         if (rnd[2:0] == 3'd0) begin
            drive_cycle(1'b0, rnd[3], 1'b0, 1'b0, 0);
         end
         while ((next_rand() % 32'd4) == 32'd0) begin
            drive_cycle(1'b1, 1'b0, last, user, nbytes);
         end
         drive_cycle(1'b1, 1'b1, last, user, nbytes);
      end
   endtask

   task automatic run_traffic(input int n_pkts);
      for (int p = 0; p < n_pkts; p++) begin
         send_packet();
      end
      idle_cycles(8);
   endtask

   initial begin
      srst        = 1'b1;
      tvalid      = 1'b0;
      tready      = 1'b0;
      tlast       = 1'b0;
      tuser       = 1'b0;
      tkeep       = '0;
      reg_req     = '0;
      model_mode  = axi4s_probe_pkg::mode_good;
      model_latch = 1'b0;
      exp_pkt     = '0;
      exp_bytes   = '0;
      snap_pkt    = '0;
      snap_bytes  = '0;
      acc         = '0;
      act_exp     = '0;
      rng         = rng_seed;
      repeat (2) @(posedge axi4s_if);
      #2;
      srst = 1'b0;
      idle_cycles(2);

      // reset values
      read_check(axi4s_probe_pkg::reg_ctrl_addr, "ctrl", 32'd0);
      check_counts();
      read_check(axi4s_probe_pkg::reg_monitor_addr, "monitor", 32'd0);
      read_check(axi4s_probe_pkg::reg_activity_addr, "activity", 32'd0);
      read_check(8'h1C, "unmapped", 32'd0);

      // good packets only
      run_traffic(40);
      check_counts();

      // clear, then errored packets of the same traffic
      write_ctrl(1'b1, 1'b0, axi4s_probe_pkg::mode_good);
      check_counts();
      rng = rng_seed;
      write_ctrl(1'b1, 1'b0, axi4s_probe_pkg::mode_errors);
      read_check(axi4s_probe_pkg::reg_ctrl_addr, "ctrl", 32'h2);
      run_traffic(40);
      check_counts();

      // stalled beats only
      write_ctrl(1'b1, 1'b0, axi4s_probe_pkg::mode_ovfl);
      read_check(axi4s_probe_pkg::reg_ctrl_addr, "ctrl", 32'h1);
      run_traffic(40);
      check_counts();

      // latched snapshots
      write_ctrl(1'b1, 1'b0, axi4s_probe_pkg::mode_good);
      run_traffic(10);
      write_ctrl(1'b0, 1'b1, axi4s_probe_pkg::mode_good);
      read_check(axi4s_probe_pkg::reg_ctrl_addr, "ctrl", 32'h4);
      run_traffic(10);
      check_counts();  // still the value of the last write
      write_ctrl(1'b0, 1'b1, axi4s_probe_pkg::mode_good);
      check_counts();

      // monitor and activity
      read_check(axi4s_probe_pkg::reg_activity_addr, "activity", {29'd0, act_exp});
      repeat (4) drive_cycle(1'b1, 1'b0, 1'b1, 1'b0, data_byte_wid);
      read_check(axi4s_probe_pkg::reg_monitor_addr, "monitor", {29'd0, 3'b101});
      idle_cycles(3);
      read_check(axi4s_probe_pkg::reg_monitor_addr, "monitor", 32'd0);
      read_check(axi4s_probe_pkg::reg_activity_addr, "activity", {29'd0, act_exp});
      read_check(axi4s_probe_pkg::reg_activity_addr, "activity", 32'd0);
      // second pattern tells every line apart
      repeat (4) drive_cycle(1'b0, 1'b1, 1'b1, 1'b0, 0);
      read_check(axi4s_probe_pkg::reg_monitor_addr, "monitor", {29'd0, 3'b011});
      idle_cycles(3);
      read_check(axi4s_probe_pkg::reg_activity_addr, "activity", {29'd0, act_exp});
      read_check(axi4s_probe_pkg::reg_activity_addr, "activity", 32'd0);

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

/* flist.f */
axi4s_probe_pkg.sv
probe_beat_qualifier.sv
probe_counters.sv
probe_reg_file.sv
axi4s_probe_top.sv
tb_axi4s_probe.sv

/* Makefile */
# Verilator build for the stream probe testbench

TOP := tb_axi4s_probe

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
